//--- rtl/datamem_pkg.sv
// Data memory shared widths, region codes, data word types and address views
package datamem_pkg;

	// Word address spans data bank and mailbox
	localparam int DM_ADDR_W = 11;

	// Index widths carried inside the address views
	localparam int DM_DATA_IDX_W = 10;
	localparam int DM_MBOX_IDX_W = 4;

	// Mailbox view skips the bits between region and index
	localparam int DM_MBOX_PAD_W = DM_ADDR_W - 1 - DM_MBOX_IDX_W;

	// Byte lanes per data word
	localparam int DM_BYTES = 4;

	// Region bit is the top address bit
	localparam logic DM_REGION_DATA = 1'b0;
	localparam logic DM_REGION_MBOX = 1'b1;

	// Data word and per-byte write enables, bit n writes byte n
	typedef logic [8*DM_BYTES-1:0] dm_word_t;
	typedef logic [DM_BYTES-1:0] dm_be_t;

	// Address seen as a core data location
	typedef struct packed {
		logic region;
		logic [DM_DATA_IDX_W-1:0] idx;
	} dm_data_view_t;

	// Address seen as a mailbox slot
	typedef struct packed {
		logic region;
		logic [DM_MBOX_PAD_W-1:0] pad;
		logic [DM_MBOX_IDX_W-1:0] idx;
	} dm_mbox_view_t;

	// One address word, decoded either way
	typedef union packed {
		dm_data_view_t data_view;
		dm_mbox_view_t mbox_view;
	} dm_addr_u;

endpackage

//--- rtl/mem_port_if.sv
// Single RAM port bundle of byte enables, word index, write data and read data
`timescale 1ns/1ps

interface mem_port_if #(
	parameter int ADDR_W = 10
);

	// Byte write enables, zero means read only
	datamem_pkg::dm_be_t we;

	// Word index into the bank
	logic [ADDR_W-1:0] idx;

	// Word to write under the enables
	datamem_pkg::dm_word_t wdata;

	// Registered old word at last index
	datamem_pkg::dm_word_t rdata;

	// Router side drives the request and takes the read word
	modport ctl (
		output we,
		output idx,
		output wdata,
		input rdata
	);

	// RAM side takes the request and returns the read word
	modport ram (
		input we,
		input idx,
		input wdata,
		output rdata
	);

endinterface

//--- rtl/byte_ram.sv
// Inferred true dual-port RAM with byte writes and read-first registered reads
`timescale 1ns/1ps

module byte_ram #(
	parameter int ADDR_W = 10
) (
	input logic con_clk,

	// Port a clock enable, low stalls the whole port
	input logic en_a,

	mem_port_if.ram port_a,
	mem_port_if.ram port_b
);

	// Words held by the bank
	localparam int DEPTH = 2 ** ADDR_W;

	// Storage, contents are never cleared
	datamem_pkg::dm_word_t mem [DEPTH];

	// Both ports share one clock, so one process covers them
	always_ff @(posedge con_clk) begin
		// Port a
		// Stalled port keeps its read word and ignores its enables
		if (en_a) begin
			// Old word leaves before any write lands
			port_a.rdata <= mem[port_a.idx];
			for (int b = 0; b < datamem_pkg::DM_BYTES; b++) begin
				if (port_a.we[b]) begin
					mem[port_a.idx][8*b +: 8] <= port_a.wdata[8*b +: 8];
				end
			end
		end

		// Port b
		// Always enabled
		port_b.rdata <= mem[port_b.idx];
		for (int b = 0; b < datamem_pkg::DM_BYTES; b++) begin
			// Same byte written from both ports: b lands last and wins
			if (port_b.we[b]) begin
				mem[port_b.idx][8*b +: 8] <= port_b.wdata[8*b +: 8];
			end
		end
	end

endmodule

//--- rtl/datamem_route.sv
// Data memory region router, gates writes per side and selects registered read data
`timescale 1ns/1ps

module datamem_route #(
	parameter int DATA_DEPTH_W = 10,
	parameter int MBOX_DEPTH_W = 4
) (
	input logic con_clk,
	input logic nrst,

	// Core stall level, low freezes the core side
	input logic core_en,

	// Core request
	input datamem_pkg::dm_be_t dm_write,
	input logic [datamem_pkg::DM_ADDR_W-1:0] exe_data_addr,
	input datamem_pkg::dm_word_t data_in,

	// Controller request
	input datamem_pkg::dm_be_t con_write,
	input logic [datamem_pkg::DM_ADDR_W-1:0] con_addr,
	input datamem_pkg::dm_word_t con_in,

	// Read words back to each side
	output datamem_pkg::dm_word_t data_out,
	output datamem_pkg::dm_word_t con_out,

	// Bank ports, a serves the core, b the controller
	mem_port_if.ctl data_a,
	mem_port_if.ctl data_b,
	mem_port_if.ctl mbox_a,
	mem_port_if.ctl mbox_b
);

	// Decoded addresses of both sides
	datamem_pkg::dm_addr_u core_addr;
	datamem_pkg::dm_addr_u ctl_addr;

	// Region hits for the write gates
	logic core_hits_data;
	logic ctl_hits_mbox;

	// Region of the read issued last cycle
	logic core_region_q;
	logic ctl_region_q;

	assign core_addr = exe_data_addr;
	assign ctl_addr = con_addr;

	// Core may only write data words, controller only mailbox words
	assign core_hits_data = core_addr.data_view.region == datamem_pkg::DM_REGION_DATA;
	assign ctl_hits_mbox = ctl_addr.mbox_view.region == datamem_pkg::DM_REGION_MBOX;

	// Core side
	// Writes also need core_en, the RAM stalls the rest of port a
	assign data_a.we = (core_hits_data && core_en) ? dm_write : '0;
	assign data_a.idx = core_addr.data_view.idx[DATA_DEPTH_W-1:0];
	assign data_a.wdata = data_in;

	// Mailbox is read only from the core
	assign mbox_a.we = '0;
	assign mbox_a.idx = core_addr.mbox_view.idx[MBOX_DEPTH_W-1:0];
	assign mbox_a.wdata = data_in;

	// Controller side
	// Data bank is read only from the controller
	assign data_b.we = '0;
	assign data_b.idx = ctl_addr.data_view.idx[DATA_DEPTH_W-1:0];
	assign data_b.wdata = con_in;

	assign mbox_b.we = ctl_hits_mbox ? con_write : '0;
	assign mbox_b.idx = ctl_addr.mbox_view.idx[MBOX_DEPTH_W-1:0];
	assign mbox_b.wdata = con_in;

	// Region registers line up with the one-cycle RAM read
	always_ff @(posedge con_clk) begin
		if (!nrst) begin
			core_region_q <= datamem_pkg::DM_REGION_DATA;
			ctl_region_q <= datamem_pkg::DM_REGION_DATA;
		end else begin
			// Core region holds with the stalled port so data_out holds too
			if (core_en) begin
				core_region_q <= core_addr.data_view.region;
			end
			ctl_region_q <= ctl_addr.mbox_view.region;
		end
	end

	// Output select by last cycle's region
	assign data_out = (core_region_q == datamem_pkg::DM_REGION_MBOX) ?
		mbox_a.rdata : data_a.rdata;
	assign con_out = (ctl_region_q == datamem_pkg::DM_REGION_MBOX) ?
		mbox_b.rdata : data_b.rdata;

endmodule

//--- rtl/datamem.sv
// Data memory top, core data bank and protocol mailbox behind one router
`timescale 1ns/1ps

module datamem #(
	// Index width of the core data bank, 1024 words
	parameter int DATA_DEPTH_W = 10,
	// Index width of the mailbox, 16 words
	parameter int MBOX_DEPTH_W = 4
) (
	input logic con_clk,
	input logic nrst,

	// Core stall level
	input logic core_en,

	// From the core memory stage
	input datamem_pkg::dm_be_t dm_write,
	input logic [datamem_pkg::DM_ADDR_W-1:0] exe_data_addr,
	input datamem_pkg::dm_word_t data_in,

	// From the protocol controller
	input datamem_pkg::dm_be_t con_write,
	input logic [datamem_pkg::DM_ADDR_W-1:0] con_addr,
	input datamem_pkg::dm_word_t con_in,

	// To the core
	output datamem_pkg::dm_word_t data_out,
	// To the protocol controller
	output datamem_pkg::dm_word_t con_out
);

	// Data bank ports
	mem_port_if #(.ADDR_W(DATA_DEPTH_W)) data_a ();
	mem_port_if #(.ADDR_W(DATA_DEPTH_W)) data_b ();

	// Mailbox ports
	mem_port_if #(.ADDR_W(MBOX_DEPTH_W)) mbox_a ();
	mem_port_if #(.ADDR_W(MBOX_DEPTH_W)) mbox_b ();

	// Address decode, write gating and read select
	datamem_route #(
		.DATA_DEPTH_W(DATA_DEPTH_W),
		.MBOX_DEPTH_W(MBOX_DEPTH_W)
	) u_route (
		.con_clk(con_clk),
		.nrst(nrst),
		.core_en(core_en),
		.dm_write(dm_write),
		.exe_data_addr(exe_data_addr),
		.data_in(data_in),
		.con_write(con_write),
		.con_addr(con_addr),
		.con_in(con_in),
		.data_out(data_out),
		.con_out(con_out),
		.data_a(data_a),
		.data_b(data_b),
		.mbox_a(mbox_a),
		.mbox_b(mbox_b)
	);

	// Core data at word addresses 0x000 to 0x3FF
	// Port a follows the core stall
	byte_ram #(
		.ADDR_W(DATA_DEPTH_W)
	) u_data_ram (
		.con_clk(con_clk),
		.en_a(core_en),
		.port_a(data_a),
		.port_b(data_b)
	);

	// Mailbox at word addresses 0x400 to 0x40F
	byte_ram #(
		.ADDR_W(MBOX_DEPTH_W)
	) u_mbox_ram (
		.con_clk(con_clk),
		.en_a(core_en),
		.port_a(mbox_a),
		.port_b(mbox_b)
	);

endmodule

//--- verif/datamem_tb.sv
// Data memory testbench driving a table of core and controller requests against a bank model
`timescale 1ns/1ps

module datamem_tb;

	localparam int CLK_PERIOD = 20;
	localparam int DATA_WORDS = 1024;
	localparam int MBOX_WORDS = 16;

	// Row mode as {nrst, core_en}
	localparam logic [1:0] RUN = 2'b11;
	localparam logic [1:0] STALL = 2'b10;
	localparam logic [1:0] RESET = 2'b01;

	// Row flags as {random data, check data_out, check con_out}
	localparam logic [2:0] CHK_NONE = 3'b000;
	localparam logic [2:0] CHK_CORE = 3'b010;
	localparam logic [2:0] CHK_BOTH = 3'b011;
	localparam logic [2:0] RND = 3'b100;

	// One table row held on the inputs for one clock
	typedef struct packed {
		logic [1:0] mode;
		datamem_pkg::dm_be_t dm_write;
		logic [datamem_pkg::DM_ADDR_W-1:0] exe_data_addr;
		datamem_pkg::dm_word_t data_in;
		datamem_pkg::dm_be_t con_write;
		logic [datamem_pkg::DM_ADDR_W-1:0] con_addr;
		datamem_pkg::dm_word_t con_in;
		logic [2:0] flags;
	} row_t;

	logic con_clk;
	logic nrst;
	logic core_en;
	datamem_pkg::dm_be_t dm_write;
	logic [datamem_pkg::DM_ADDR_W-1:0] exe_data_addr;
	datamem_pkg::dm_word_t data_in;
	datamem_pkg::dm_be_t con_write;
	logic [datamem_pkg::DM_ADDR_W-1:0] con_addr;
	datamem_pkg::dm_word_t con_in;
	datamem_pkg::dm_word_t data_out;
	datamem_pkg::dm_word_t con_out;

	row_t rows[$];
	logic table_ready = 1'b0;
	int checks_done = 0;
	logic [31:0] lcg_state;

	// Bank model and the words each port read last
	datamem_pkg::dm_word_t data_model [DATA_WORDS];
	datamem_pkg::dm_word_t mbox_model [MBOX_WORDS];
	datamem_pkg::dm_word_t m_core_data_rd;
	datamem_pkg::dm_word_t m_core_mbox_rd;
	datamem_pkg::dm_word_t m_ctl_data_rd;
	datamem_pkg::dm_word_t m_ctl_mbox_rd;
	logic m_core_region;
	logic m_ctl_region;

	datamem #(
		.DATA_DEPTH_W(10),
		.MBOX_DEPTH_W(4)
	) u_datamem (
		.con_clk(con_clk),
		.nrst(nrst),
		.core_en(core_en),
		.dm_write(dm_write),
		.exe_data_addr(exe_data_addr),
		.data_in(data_in),
		.con_write(con_write),
		.con_addr(con_addr),
		.con_in(con_in),
		.data_out(data_out),
		.con_out(con_out)
	);

	initial begin
		con_clk = 1'b0;
		forever #(CLK_PERIOD / 2) con_clk = ~con_clk;
	end

	// Numerical Recipes LCG step
	function automatic datamem_pkg::dm_word_t next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic add_row(input logic [1:0] mode, input datamem_pkg::dm_be_t cw,
		input logic [10:0] ca, input datamem_pkg::dm_word_t cd,
		input datamem_pkg::dm_be_t xw, input logic [10:0] xa,
		input datamem_pkg::dm_word_t xd, input logic [2:0] flags);
		row_t r;
		r = {mode, cw, ca, cd, xw, xa, xd, flags};
		rows.push_back(r);
	endtask

	// Columns are mode, core be, core addr, core data, ctl be, ctl addr, ctl data, flags
	task automatic fill_table();
		// Seed known words in both banks
		add_row(RUN, 4'hf, 11'h005, 32'h1122_3344, 4'hf, 11'h405, 32'ha5a5_5a5a, CHK_NONE);
		add_row(RUN, 4'hf, 11'h006, 32'h0, 4'hf, 11'h40a, 32'h0, RND);
		add_row(RUN, 4'h0, 11'h005, 32'h0, 4'h0, 11'h405, 32'h0, CHK_BOTH);
		// Partial byte write shows the old word first and the merged word next
		add_row(RUN, 4'b0101, 11'h005, 32'hdead_beef, 4'h0, 11'h005, 32'h0, CHK_BOTH);
		add_row(RUN, 4'h0, 11'h005, 32'h0, 4'h0, 11'h005, 32'h0, CHK_BOTH);
		// Controller fills a mailbox slot and both sides read it
		// Old slot word was never written, so only the core side is compared here
		add_row(RUN, 4'h0, 11'h006, 32'h0, 4'hf, 11'h403, 32'h0, RND | CHK_CORE);
		add_row(RUN, 4'h0, 11'h403, 32'h0, 4'h0, 11'h403, 32'h0, CHK_BOTH);
		// Writes into the wrong region are dropped
		add_row(RUN, 4'hf, 11'h405, 32'hffff_ffff, 4'hf, 11'h005, 32'h0, CHK_BOTH);
		add_row(RUN, 4'h0, 11'h005, 32'h0, 4'h0, 11'h405, 32'h0, CHK_BOTH);
		add_row(RUN, 4'h0, 11'h405, 32'h0, 4'h0, 11'h005, 32'h0, CHK_BOTH);
		// Same index written and read on one cycle
		add_row(RUN, 4'hf, 11'h006, 32'h0, 4'h0, 11'h006, 32'h0, RND | CHK_BOTH);
		add_row(RUN, 4'h0, 11'h006, 32'h0, 4'h0, 11'h006, 32'h0, CHK_BOTH);
		add_row(RUN, 4'h0, 11'h40a, 32'h0, 4'b1100, 11'h40a, 32'h0, RND | CHK_BOTH);
		add_row(RUN, 4'h0, 11'h40a, 32'h0, 4'h0, 11'h40a, 32'h0, CHK_BOTH);
		// Core stalled while the controller keeps going
		add_row(RUN, 4'h0, 11'h005, 32'h0, 4'h0, 11'h006, 32'h0, CHK_BOTH);
		add_row(STALL, 4'hf, 11'h005, 32'h0bad_0bad, 4'hf, 11'h403, 32'h600d_f00d, CHK_BOTH);
		add_row(STALL, 4'h0, 11'h40a, 32'h0, 4'h0, 11'h403, 32'h0, CHK_BOTH);
		add_row(RUN, 4'h0, 11'h005, 32'h0, 4'h0, 11'h005, 32'h0, CHK_BOTH);
		// Reset pulls both selects back to the data bank
		add_row(RUN, 4'h0, 11'h405, 32'h0, 4'h0, 11'h405, 32'h0, CHK_BOTH);
		add_row(RESET, 4'h0, 11'h405, 32'h0, 4'h0, 11'h405, 32'h0, CHK_BOTH);
		add_row(RESET, 4'h0, 11'h405, 32'h0, 4'h0, 11'h405, 32'h0, CHK_BOTH);
		add_row(RUN, 4'h0, 11'h405, 32'h0, 4'h0, 11'h405, 32'h0, CHK_BOTH);
		// Top words of both banks
		add_row(RUN, 4'hf, 11'h3ff, 32'h0, 4'hf, 11'h40f, 32'h0, RND);
		add_row(RUN, 4'h0, 11'h40f, 32'h0, 4'h0, 11'h3ff, 32'h0, CHK_BOTH);
		add_row(RUN, 4'h0, 11'h3ff, 32'h0, 4'h0, 11'h40f, 32'h0, CHK_BOTH);
	endtask

	task automatic drive_row(input row_t r);
		nrst <= r.mode[1];
		core_en <= r.mode[0];
		dm_write <= r.dm_write;
		exe_data_addr <= r.exe_data_addr;
		data_in <= r.data_in;
		con_write <= r.con_write;
		con_addr <= r.con_addr;
		con_in <= r.con_in;
	endtask

	// Enabled bytes come from the new word and the rest stay
	function automatic datamem_pkg::dm_word_t merge_bytes(
		input datamem_pkg::dm_word_t old_w,
		input datamem_pkg::dm_word_t new_w, input datamem_pkg::dm_be_t be);
		datamem_pkg::dm_word_t w;
		w = old_w;
		for (int b = 0; b < 4; b++) begin
			if (be[b]) begin
				w[8*b +: 8] = new_w[8*b +: 8];
			end
		end
		return w;
	endfunction

	// One clock of the memory rules giving both outputs after that clock
	task automatic step_model(input row_t r, output datamem_pkg::dm_word_t exp_core,
		output datamem_pkg::dm_word_t exp_con);
		datamem_pkg::dm_addr_u ca;
		datamem_pkg::dm_addr_u xa;
		logic en;
		ca = r.exe_data_addr;
		xa = r.con_addr;
		en = r.mode[0];
		// Old words leave before this clock's writes
		if (en) begin
			m_core_data_rd = data_model[ca.data_view.idx];
			m_core_mbox_rd = mbox_model[ca.mbox_view.idx];
		end
		m_ctl_data_rd = data_model[xa.data_view.idx];
		m_ctl_mbox_rd = mbox_model[xa.mbox_view.idx];
		if (!r.mode[1]) begin
			m_core_region = datamem_pkg::DM_REGION_DATA;
			m_ctl_region = datamem_pkg::DM_REGION_DATA;
		end else begin
			if (en) begin
				m_core_region = ca.data_view.region;
			end
			m_ctl_region = xa.mbox_view.region;
		end
		// Core writes data words only and the controller mailbox words only
		if (en && ca.data_view.region == datamem_pkg::DM_REGION_DATA) begin
			data_model[ca.data_view.idx] =
				merge_bytes(data_model[ca.data_view.idx], r.data_in, r.dm_write);
		end
		if (xa.mbox_view.region == datamem_pkg::DM_REGION_MBOX) begin
			mbox_model[xa.mbox_view.idx] =
				merge_bytes(mbox_model[xa.mbox_view.idx], r.con_in, r.con_write);
		end
		// Each side shows the bank its registered region points at
		exp_core = (m_core_region == datamem_pkg::DM_REGION_MBOX) ?
			m_core_mbox_rd : m_core_data_rd;
		exp_con = (m_ctl_region == datamem_pkg::DM_REGION_MBOX) ?
			m_ctl_mbox_rd : m_ctl_data_rd;
	endtask

	task automatic check_word(input datamem_pkg::dm_word_t got,
		input datamem_pkg::dm_word_t exp, input string name);
		checks_done++;
		if (got !== exp) begin
			$display("CHECK FAILED at %0t ns: %s got %h expected %h",
				$time, name, got, exp);
			$display("Something failed");
			$fatal(1, "Read data mismatch");
		end
	endtask

	// Watchdog sized from the table length
	initial begin
		wait (table_ready);
		#((rows.size() + 20) * CLK_PERIOD);
		$display("Something failed");
		$fatal(1, "Timeout, the stimulus table did not finish in time");
	end

	initial begin
		row_t r;
		datamem_pkg::dm_word_t exp_core;
		datamem_pkg::dm_word_t exp_con;
		nrst = 1'b0;
		core_en = 1'b0;
		dm_write = '0;
		exe_data_addr = '0;
		data_in = '0;
		con_write = '0;
		con_addr = '0;
		con_in = '0;
		lcg_state = 32'hd7dd_1780;
		m_core_region = datamem_pkg::DM_REGION_DATA;
		m_ctl_region = datamem_pkg::DM_REGION_DATA;
		fill_table();
		table_ready = 1'b1;
		repeat (2) @(posedge con_clk);
		// Row i goes out while the DUT shows the result of row i-1
		for (int i = 0; i <= rows.size(); i++) begin
			if (i < rows.size()) begin
				r = rows[i];
				if (r.flags[2]) begin
					r.data_in = next_rand();
					r.con_in = next_rand();
					rows[i] = r;
				end
			end else begin
				r = '0;
				r.mode = RUN;
			end
			drive_row(r);
			@(negedge con_clk);
			if (i > 0) begin
				step_model(rows[i-1], exp_core, exp_con);
				if (rows[i-1].flags[1]) begin
					check_word(data_out, exp_core, "data_out");
				end
				if (rows[i-1].flags[0]) begin
					check_word(con_out, exp_con, "con_out");
				end
			end
			@(posedge con_clk);
		end
		if (checks_done > 0) begin
			$display("Everything OK");
			$finish;
		end else begin
			$display("Something failed");
			$fatal(1, "No output was checked");
		end
	end

endmodule

//--- datamem.f
rtl/datamem_pkg.sv
rtl/mem_port_if.sv
rtl/byte_ram.sv
rtl/datamem_route.sv
rtl/datamem.sv
verif/datamem_tb.sv

//--- Makefile
# Verilator build and run of the data memory testbench

VERILATOR ?= verilator
TOP ?= datamem_tb
FILELIST ?= datamem.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing -j 0

.PHONY: sim clean

# Build and run, the exit status carries pass or fail
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
